/* stream_pkg.sv */
package stream_pkg;

    // Beat width in bytes; keep_t and data_t are sized from this
    localparam int DATA_BYTES = 8;

    typedef logic [7:0] byte_t;

    // Byte-enable mask, one bit per data byte
    typedef logic [DATA_BYTES-1:0] keep_t;

    // One beat of data, byte 0 in the low bits
    typedef byte_t [DATA_BYTES-1:0] data_t;

    // Beats held in one path
    typedef logic [7:0] occ_t;

    // Path control FSM
    typedef enum logic {
        PASS,
        DRAIN
    } ctrl_state_t;

endpackage : stream_pkg

/* reg_slice.sv */
`timescale 1ns/1ps

module reg_slice
    import stream_pkg::*;
#(
    parameter int DATA_BYTES = 8
) (
    input  logic  from_tx,
    input  logic  aresetn,

    input  logic  in_tvalid,
    output logic  in_tready,
    input  data_t in_tdata,
    input  keep_t in_tkeep,
    input  logic  in_tlast,

    output logic  out_tvalid,
    input  logic  out_tready,
    output data_t out_tdata,
    output keep_t out_tkeep,
    output logic  out_tlast
);
    logic                   valid_q;
    byte_t [DATA_BYTES-1:0] data_q;
    logic  [DATA_BYTES-1:0] keep_q;
    logic                   last_q;

    // Take a beat when empty or when the held one leaves now
    assign in_tready = !valid_q || out_tready;

    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (in_tready) begin
            valid_q <= in_tvalid;
        end
    end

    always_ff @(posedge from_tx) begin
        if (in_tvalid && in_tready) begin
            data_q <= in_tdata;
            keep_q <= in_tkeep;
            last_q <= in_tlast;
        end
    end

    assign out_tvalid = valid_q;
    assign out_tdata  = data_q;
    assign out_tkeep  = keep_q;
    assign out_tlast  = last_q;

endmodule : reg_slice

/* tlast_advance.sv */
`timescale 1ns/1ps

module tlast_advance
    import stream_pkg::*;
#(
    parameter int DATA_BYTES = 8
) (
    input  logic  from_tx,
    input  logic  aresetn,

    input  logic  in_tvalid,
    output logic  in_tready,
    input  data_t in_tdata,
    input  keep_t in_tkeep,
    input  logic  in_tlast,

    output logic  out_tvalid,
    input  logic  out_tready,
    output data_t out_tdata,
    output keep_t out_tkeep,
    output logic  out_tlast,

    // Pulses when a zero-keep last beat is swallowed
    output logic  drop
);
    // Held beat, waiting to learn whether it ends the packet
    logic                   pend_valid;
    byte_t [DATA_BYTES-1:0] pend_data;
    logic  [DATA_BYTES-1:0] pend_keep;
    logic                   pend_last;

    // Output register
    logic                   oreg_valid;
    byte_t [DATA_BYTES-1:0] oreg_data;
    logic  [DATA_BYTES-1:0] oreg_keep;
    logic                   oreg_last;

    logic out_free;
    logic in_xfer;
    logic in_empty_last;
    logic pend_release;
    logic load_out_pend;
    logic load_out_in;
    logic load_pend;
    logic force_last;

    assign out_free      = !oreg_valid || out_tready;
    // Stall one cycle while a held last beat moves out
    assign in_tready     = out_free && !(pend_valid && pend_last);
    assign in_xfer       = in_tvalid && in_tready;
    assign in_empty_last = in_tlast && (in_tkeep == '0);
    assign drop          = in_xfer && in_empty_last;

    // A held last beat needs no successor to leave
    assign pend_release  = pend_valid && pend_last && out_free;
    assign load_out_pend = pend_release || (in_xfer && pend_valid);
    assign load_out_in   = in_xfer && !pend_valid && in_tlast && !in_empty_last;
    assign load_pend     = in_xfer && !in_empty_last && (pend_valid || !in_tlast);
    assign force_last    = in_xfer && pend_valid && in_empty_last;

    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            pend_valid <= 1'b0;
            oreg_valid <= 1'b0;
        end else begin
            if (load_pend) begin
                pend_valid <= 1'b1;
            end else if (load_out_pend) begin
                pend_valid <= 1'b0;
            end

            if (load_out_pend || load_out_in) begin
                oreg_valid <= 1'b1;
            end else if (out_tready) begin
                oreg_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge from_tx) begin
        if (load_pend) begin
            pend_data <= in_tdata;
            pend_keep <= in_tkeep;
            pend_last <= in_tlast;
        end

        if (load_out_pend) begin
            oreg_data <= pend_data;
            oreg_keep <= pend_keep;
            // tlast moves forward from the swallowed beat
            oreg_last <= pend_last || force_last;
        end else if (load_out_in) begin
            oreg_data <= in_tdata;
            oreg_keep <= in_tkeep;
            oreg_last <= 1'b1;
        end
    end

    assign out_tvalid = oreg_valid;
    assign out_tdata  = oreg_data;
    assign out_tkeep  = oreg_keep;
    assign out_tlast  = oreg_last;

    a_no_empty_last : assert property (@(posedge from_tx) disable iff (!aresetn)
        out_tvalid && out_tlast |-> out_tkeep != '0);

endmodule : tlast_advance

/* path_ctrl.sv */
`timescale 1ns/1ps

module path_ctrl
    import stream_pkg::*;
#(
    parameter int PIPE_STAGES = 2
) (
    input  logic  from_tx,
    input  logic  aresetn,

    input  logic  in_tvalid,
    output logic  in_tready,
    input  data_t in_tdata,
    input  keep_t in_tkeep,
    input  logic  in_tlast,

    input  logic  bypass,

    output logic  out_tvalid,
    input  logic  out_tready,
    output data_t out_tdata,
    output keep_t out_tkeep,
    output logic  out_tlast,

    // Toward and from the processing path
    output logic  proc_tvalid,
    input  logic  proc_tready,
    output data_t proc_tdata,
    output keep_t proc_tkeep,
    output logic  proc_tlast,
    input  logic  proc_out_tvalid,
    output logic  proc_out_tready,
    input  data_t proc_out_tdata,
    input  keep_t proc_out_tkeep,
    input  logic  proc_out_tlast,
    input  logic  proc_drop,

    // Toward and from the bypass slices
    output logic  byp_in_tvalid,
    input  logic  byp_in_tready,
    output data_t byp_in_tdata,
    output keep_t byp_in_tkeep,
    output logic  byp_in_tlast,
    input  logic  byp_out_tvalid,
    output logic  byp_out_tready,
    input  data_t byp_out_tdata,
    input  keep_t byp_out_tkeep,
    input  logic  byp_out_tlast
);
    // Pending beat plus output register in the processing path
    localparam occ_t PROC_DEPTH = occ_t'(2);

    ctrl_state_t state;
    logic        sop;
    logic        sel_byp;
    logic        switch_req;
    logic        in_open;
    logic        in_xfer;
    logic        proc_in_xfer;
    logic        proc_out_xfer;
    logic        byp_in_xfer;
    logic        byp_out_xfer;
    occ_t        proc_cnt;
    occ_t        byp_cnt;
    occ_t        active_cnt;

    // New setting only counts at a packet boundary
    assign switch_req = (state == PASS) && sop && (bypass != sel_byp);
    assign in_open    = (state == PASS) && !switch_req;

    // Input steering
    assign proc_tvalid   = in_tvalid && in_open && !sel_byp;
    assign proc_tdata    = in_tdata;
    assign proc_tkeep    = in_tkeep;
    assign proc_tlast    = in_tlast;
    assign byp_in_tvalid = in_tvalid && in_open && sel_byp;
    assign byp_in_tdata  = in_tdata;
    assign byp_in_tkeep  = in_tkeep;
    assign byp_in_tlast  = in_tlast;
    assign in_tready     = in_open && (sel_byp ? byp_in_tready : proc_tready);

    // Output merge
    assign out_tvalid      = sel_byp ? byp_out_tvalid : proc_out_tvalid;
    assign out_tdata       = sel_byp ? byp_out_tdata  : proc_out_tdata;
    assign out_tkeep       = sel_byp ? byp_out_tkeep  : proc_out_tkeep;
    assign out_tlast       = sel_byp ? byp_out_tlast  : proc_out_tlast;
    assign proc_out_tready = out_tready && !sel_byp;
    assign byp_out_tready  = out_tready && sel_byp;

    assign in_xfer       = in_tvalid && in_tready;
    assign proc_in_xfer  = in_xfer && !sel_byp;
    assign byp_in_xfer   = in_xfer && sel_byp;
    assign proc_out_xfer = proc_out_tvalid && proc_out_tready;
    assign byp_out_xfer  = byp_out_tvalid && byp_out_tready;
    assign active_cnt    = sel_byp ? byp_cnt : proc_cnt;

    // Start of packet tracking
    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            sop <= 1'b1;
        end else if (in_xfer) begin
            sop <= in_tlast;
        end
    end

    // Path drain FSM
    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            state   <= PASS;
            sel_byp <= bypass;
        end else begin
            case (state)
                PASS: begin
                    if (switch_req) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // Old path empty, safe to flip
                    if (active_cnt == '0) begin
                        sel_byp <= !sel_byp;
                        state   <= PASS;
                    end
                end
                default: state <= PASS;
            endcase
        end
    end

    // Beats in flight per path; a dropped beat leaves when it is accepted
    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            proc_cnt <= '0;
            byp_cnt  <= '0;
        end else begin
            proc_cnt <= proc_cnt + occ_t'(proc_in_xfer) - occ_t'(proc_out_xfer)
                        - occ_t'(proc_drop);
            byp_cnt  <= byp_cnt + occ_t'(byp_in_xfer) - occ_t'(byp_out_xfer);
        end
    end

    a_out_stable : assert property (@(posedge from_tx) disable iff (!aresetn)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) &&
        $stable(out_tkeep) && $stable(out_tlast));

    a_proc_cnt : assert property (@(posedge from_tx) disable iff (!aresetn)
        proc_cnt <= PROC_DEPTH);

    a_byp_cnt : assert property (@(posedge from_tx) disable iff (!aresetn)
        byp_cnt <= occ_t'(PIPE_STAGES));

endmodule : path_ctrl

/* bypass_stream_top.sv */
`timescale 1ns/1ps

module bypass_stream_top
    import stream_pkg::*;
#(
    parameter int DATA_BYTES  = 8,
    parameter int PIPE_STAGES = 2
) (
    input  logic  from_tx,
    input  logic  aresetn,

    input  logic  in_tvalid,
    output logic  in_tready,
    input  data_t in_tdata,
    input  keep_t in_tkeep,
    input  logic  in_tlast,

    input  logic  bypass,

    output logic  out_tvalid,
    input  logic  out_tready,
    output data_t out_tdata,
    output keep_t out_tkeep,
    output logic  out_tlast
);
    // Processing path links
    logic  proc_tvalid;
    logic  proc_tready;
    data_t proc_tdata;
    keep_t proc_tkeep;
    logic  proc_tlast;
    logic  proc_out_tvalid;
    logic  proc_out_tready;
    data_t proc_out_tdata;
    keep_t proc_out_tkeep;
    logic  proc_out_tlast;
    logic  proc_drop;

    // Bypass chain, index 0 is the chain input and PIPE_STAGES its output
    logic [PIPE_STAGES:0] stg_tvalid;
    logic [PIPE_STAGES:0] stg_tready;
    data_t                stg_tdata [0:PIPE_STAGES];
    keep_t                stg_tkeep [0:PIPE_STAGES];
    logic [PIPE_STAGES:0] stg_tlast;

    path_ctrl #(
        .PIPE_STAGES(PIPE_STAGES)
    ) u_path_ctrl (
        .from_tx        (from_tx),
        .aresetn        (aresetn),
        .in_tvalid      (in_tvalid),
        .in_tready      (in_tready),
        .in_tdata       (in_tdata),
        .in_tkeep       (in_tkeep),
        .in_tlast       (in_tlast),
        .bypass         (bypass),
        .out_tvalid     (out_tvalid),
        .out_tready     (out_tready),
        .out_tdata      (out_tdata),
        .out_tkeep      (out_tkeep),
        .out_tlast      (out_tlast),
        .proc_tvalid    (proc_tvalid),
        .proc_tready    (proc_tready),
        .proc_tdata     (proc_tdata),
        .proc_tkeep     (proc_tkeep),
        .proc_tlast     (proc_tlast),
        .proc_out_tvalid(proc_out_tvalid),
        .proc_out_tready(proc_out_tready),
        .proc_out_tdata (proc_out_tdata),
        .proc_out_tkeep (proc_out_tkeep),
        .proc_out_tlast (proc_out_tlast),
        .proc_drop      (proc_drop),
        .byp_in_tvalid  (stg_tvalid[0]),
        .byp_in_tready  (stg_tready[0]),
        .byp_in_tdata   (stg_tdata[0]),
        .byp_in_tkeep   (stg_tkeep[0]),
        .byp_in_tlast   (stg_tlast[0]),
        .byp_out_tvalid (stg_tvalid[PIPE_STAGES]),
        .byp_out_tready (stg_tready[PIPE_STAGES]),
        .byp_out_tdata  (stg_tdata[PIPE_STAGES]),
        .byp_out_tkeep  (stg_tkeep[PIPE_STAGES]),
        .byp_out_tlast  (stg_tlast[PIPE_STAGES])
    );

    tlast_advance #(
        .DATA_BYTES(DATA_BYTES)
    ) u_tlast_advance (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_tvalid (proc_tvalid),
        .in_tready (proc_tready),
        .in_tdata  (proc_tdata),
        .in_tkeep  (proc_tkeep),
        .in_tlast  (proc_tlast),
        .out_tvalid(proc_out_tvalid),
        .out_tready(proc_out_tready),
        .out_tdata (proc_out_tdata),
        .out_tkeep (proc_out_tkeep),
        .out_tlast (proc_out_tlast),
        .drop      (proc_drop)
    );

    for (genvar i = 0; i < PIPE_STAGES; i++) begin : g_byp_stage
        reg_slice #(
            .DATA_BYTES(DATA_BYTES)
        ) u_reg_slice (
            .from_tx   (from_tx),
            .aresetn   (aresetn),
            .in_tvalid (stg_tvalid[i]),
            .in_tready (stg_tready[i]),
            .in_tdata  (stg_tdata[i]),
            .in_tkeep  (stg_tkeep[i]),
            .in_tlast  (stg_tlast[i]),
            .out_tvalid(stg_tvalid[i+1]),
            .out_tready(stg_tready[i+1]),
            .out_tdata (stg_tdata[i+1]),
            .out_tkeep (stg_tkeep[i+1]),
            .out_tlast (stg_tlast[i+1])
        );
    end

endmodule : bypass_stream_top

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic from_tx,
    output logic aresetn
);
    initial begin
        from_tx = 1'b0;
        forever #HALF_PERIOD from_tx = !from_tx;
    end

    // Reset low for the first edges, released on a rising edge
    initial begin
        aresetn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge from_tx);
        aresetn <= 1'b1;
    end

endmodule : tb_clock_gen

/* tb_bypass_stream.sv */
`timescale 1ns/1ps

module tb_bypass_stream
    import stream_pkg::*;
();
    localparam int PIPE_STAGES = 2;
    localparam int NUM_PKTS    = 300;
    localparam int TIMEOUT     = 1000;

    logic  from_tx;
    logic  aresetn;
    logic  in_tvalid;
    logic  in_tready;
    data_t in_tdata;
    keep_t in_tkeep;
    logic  in_tlast;
    logic  bypass;
    logic  out_tvalid;
    logic  out_tready;
    data_t out_tdata;
    keep_t out_tkeep;
    logic  out_tlast;

    int seed = 79679;

    // Reference queue of expected output beats
    data_t exp_data_q [$];
    keep_t exp_keep_q [$];
    logic  exp_last_q [$];
    logic  exp_byp_q  [$];
    logic  model_sop;
    logic  pkt_byp;

    // Registered view of the queue front for the checks
    int    exp_count;
    data_t exp_tdata;
    keep_t exp_tkeep;
    logic  exp_tlast;
    logic  exp_byp;
    logic  accepted;
    logic  tail_lost;

    // Output as seen on the previous edge
    logic  stalled;
    data_t held_tdata;
    keep_t held_tkeep;
    logic  held_tlast;

    tb_clock_gen u_tb_clock_gen (
        .from_tx(from_tx),
        .aresetn(aresetn)
    );

    bypass_stream_top #(
        .DATA_BYTES (DATA_BYTES),
        .PIPE_STAGES(PIPE_STAGES)
    ) u_bypass_stream_top (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_tvalid (in_tvalid),
        .in_tready (in_tready),
        .in_tdata  (in_tdata),
        .in_tkeep  (in_tkeep),
        .in_tlast  (in_tlast),
        .bypass    (bypass),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready),
        .out_tdata (out_tdata),
        .out_tkeep (out_tkeep),
        .out_tlast (out_tlast)
    );

    task automatic stop_on_error(input string what);
        $display("Simulation failed");
        $display("error: %s", what);
        $fatal(1, "run stopped at first error");
    endtask

    task automatic stop_on_mismatch(input string test, input logic [63:0] expected,
                                    input logic [63:0] actual);
        $display("Simulation failed");
        $display("mismatch %s expected %h actual %h", test, expected, actual);
        $fatal(1, "run stopped at first error");
    endtask

    function automatic data_t rand_data();
        data_t d;
        for (int i = 0; i < DATA_BYTES; i++) begin
            d[i] = byte_t'($random(seed));
        end
        return d;
    endfunction

    function automatic keep_t rand_keep();
        keep_t k;
        k = keep_t'($random(seed));
        if (k == '0) begin
            k = keep_t'(1);
        end
        return k;
    endfunction

    // Offer one beat and hold it until accepted
    task automatic send_beat(input data_t data, input keep_t keep, input logic last);
        int cnt;
        cnt = 0;
        if ($unsigned($random(seed)) % 4 == 0) begin
            in_tvalid <= 1'b0;
            @(posedge from_tx);
        end
        in_tvalid <= 1'b1;
        in_tdata  <= data;
        in_tkeep  <= keep;
        in_tlast  <= last;
        // Bypass also flips at random in mid-packet
        if ($unsigned($random(seed)) % 5 == 0) begin
            bypass <= !bypass;
        end
        @(posedge from_tx);
        while (!in_tready && cnt < TIMEOUT) begin
            @(posedge from_tx);
            cnt++;
        end
        if (!in_tready) begin
            stop_on_error("input beat was not accepted before the timeout");
        end
    endtask

    always @(posedge from_tx) begin
        out_tready <= ($unsigned($random(seed)) % 4) != 0;
    end

    always @(posedge from_tx) begin
        stalled    <= out_tvalid && !out_tready;
        held_tdata <= out_tdata;
        held_tkeep <= out_tkeep;
        held_tlast <= out_tlast;
    end

    always @(posedge from_tx) begin
        if (!aresetn) begin
            exp_data_q.delete();
            exp_keep_q.delete();
            exp_last_q.delete();
            exp_byp_q.delete();
            model_sop = 1'b1;
            pkt_byp   = 1'b0;
            accepted  <= 1'b0;
            tail_lost <= 1'b0;
            exp_count <= 0;
        end else begin
            if (out_tvalid && out_tready && exp_data_q.size() != 0) begin
                exp_data_q.delete(0);
                exp_keep_q.delete(0);
                exp_last_q.delete(0);
                exp_byp_q.delete(0);
            end
            if (in_tvalid && in_tready) begin
                // Path is fixed by the setting at the first beat
                if (model_sop) begin
                    pkt_byp = bypass;
                end
                if (!pkt_byp && in_tlast && in_tkeep == '0) begin
                    // Empty closing beat vanishes and its tlast moves back one beat
                    if (exp_last_q.size() == 0) begin
                        tail_lost <= 1'b1;
                    end else begin
                        exp_last_q[exp_last_q.size()-1] = 1'b1;
                    end
                end else begin
                    exp_data_q.push_back(in_tdata);
                    exp_keep_q.push_back(in_tkeep);
                    exp_last_q.push_back(in_tlast);
                    exp_byp_q.push_back(pkt_byp);
                end
                model_sop = in_tlast;
                accepted  <= 1'b1;
            end
            exp_count <= exp_data_q.size();
            if (exp_data_q.size() != 0) begin
                exp_tdata <= exp_data_q[0];
                exp_tkeep <= exp_keep_q[0];
                exp_tlast <= exp_last_q[0];
                exp_byp   <= exp_byp_q[0];
            end
        end
    end

    a_idle_after_reset : assert property (@(posedge from_tx) disable iff (!aresetn)
        !accepted |-> !out_tvalid)
        else stop_on_mismatch("idle_after_reset", 64'(0), 64'($sampled(out_tvalid)));

    a_out_expected : assert property (@(posedge from_tx) disable iff (!aresetn)
        out_tvalid |-> exp_count != 0)
        else stop_on_error("output beat appeared with no beat expected");

    a_out_data : assert property (@(posedge from_tx) disable iff (!aresetn)
        out_tvalid && exp_count != 0 |-> out_tdata == exp_tdata)
        else stop_on_mismatch("out_tdata", 64'($sampled(exp_tdata)),
                              64'($sampled(out_tdata)));

    a_out_keep : assert property (@(posedge from_tx) disable iff (!aresetn)
        out_tvalid && exp_count != 0 |-> out_tkeep == exp_tkeep)
        else stop_on_mismatch("out_tkeep", 64'($sampled(exp_tkeep)),
                              64'($sampled(out_tkeep)));

    a_out_last : assert property (@(posedge from_tx) disable iff (!aresetn)
        out_tvalid && exp_count != 0 |-> out_tlast == exp_tlast)
        else stop_on_mismatch("out_tlast", 64'($sampled(exp_tlast)),
                              64'($sampled(out_tlast)));

    a_no_empty_last : assert property (@(posedge from_tx) disable iff (!aresetn)
        out_tvalid && out_tlast && exp_count != 0 && !exp_byp |-> out_tkeep != '0)
        else stop_on_error("processing path delivered a last beat with zero keep");

    a_tail_kept : assert property (@(posedge from_tx) disable iff (!aresetn)
        !tail_lost)
        else stop_on_error("beat before a zero-keep last left without its tlast");

    a_stall_valid : assert property (@(posedge from_tx) disable iff (!aresetn)
        stalled |-> out_tvalid)
        else stop_on_mismatch("stall_valid", 64'(1), 64'($sampled(out_tvalid)));

    a_stall_data : assert property (@(posedge from_tx) disable iff (!aresetn)
        stalled |-> out_tdata == held_tdata)
        else stop_on_mismatch("stall_data", 64'($sampled(held_tdata)),
                              64'($sampled(out_tdata)));

    a_stall_keep : assert property (@(posedge from_tx) disable iff (!aresetn)
        stalled |-> out_tkeep == held_tkeep)
        else stop_on_mismatch("stall_keep", 64'($sampled(held_tkeep)),
                              64'($sampled(out_tkeep)));

    a_stall_last : assert property (@(posedge from_tx) disable iff (!aresetn)
        stalled |-> out_tlast == held_tlast)
        else stop_on_mismatch("stall_last", 64'($sampled(held_tlast)),
                              64'($sampled(out_tlast)));

    initial begin
        int n_beats;
        logic zero_end;
        int cnt;
        in_tvalid  <= 1'b0;
        in_tdata   <= '0;
        in_tkeep   <= '0;
        in_tlast   <= 1'b0;
        bypass     <= 1'b0;
        out_tready <= 1'b0;
        cnt = 0;
        @(posedge from_tx);
        while (!aresetn && cnt < TIMEOUT) begin
            @(posedge from_tx);
            cnt++;
        end
        if (!aresetn) begin
            stop_on_error("reset was never released");
        end

        for (int p = 0; p < NUM_PKTS; p++) begin
            n_beats  = 1 + int'($unsigned($random(seed)) % 6);
            zero_end = (n_beats > 1) && ($unsigned($random(seed)) % 3 == 0);
            for (int b = 0; b < n_beats; b++) begin
                if (b == n_beats - 1 && zero_end) begin
                    send_beat(rand_data(), '0, 1'b1);
                end else begin
                    send_beat(rand_data(), rand_keep(), b == n_beats - 1);
                end
            end
        end
        in_tvalid <= 1'b0;

        // Let both paths empty out
        cnt = 0;
        @(posedge from_tx);
        while (exp_count != 0 && cnt < TIMEOUT) begin
            @(posedge from_tx);
            cnt++;
        end
        repeat (2 * PIPE_STAGES + 4) @(posedge from_tx);

        if (exp_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_on_error("expected output beats still missing after the drain timeout");
        end
    end

endmodule : tb_bypass_stream

/* verilog.f */
stream_pkg.sv
reg_slice.sv
tlast_advance.sv
path_ctrl.sv
bypass_stream_top.sv
tb_clock_gen.sv
tb_bypass_stream.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_bypass_stream -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }
